// File: hw/isa_pkg.sv
//--------------------
// isa_pkg
// instruction formats and encodings of the MIPS-style integer ISA
//--------------------
`default_nettype none

package isa_pkg;

    localparam int OPCODE_W = 6;
    localparam int REG_W    = 5;
    localparam int IMM_W    = 16;
    localparam int NUM_REGS = 32;

    typedef logic [31:0]      word_t;
    typedef logic [REG_W-1:0] reg_addr_t;

    typedef enum logic [OPCODE_W-1:0] {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        reg_addr_t           rs;
        reg_addr_t           rt;
        reg_addr_t           rd;
        logic [4:0]          shamt;
        logic [5:0]          funct;
    } r_type_t;

    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        reg_addr_t           rs;
        reg_addr_t           rt;
        logic [IMM_W-1:0]    imm;
    } i_type_t;

endpackage

`default_nettype wire

// File: hw/core_pkg.sv
//--------------------
// core_pkg
// control bundle and per-stage payloads of the pipeline
//--------------------
`default_nettype none

package core_pkg;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    use_imm;   // operand b from immediate
        logic    uses_rt;   // rt is a source
        alu_op_e alu_op;
    } ctrl_t;

    localparam ctrl_t ctrl_nop = ctrl_t'('0);

    typedef struct packed {
        ctrl_t              ctrl;
        isa_pkg::word_t     rs_val;
        isa_pkg::word_t     rt_val;
        isa_pkg::word_t     imm;
        isa_pkg::reg_addr_t dst;
    } id_ex_t;

    typedef struct packed {
        ctrl_t              ctrl;
        isa_pkg::word_t     alu_result;
        isa_pkg::word_t     store_data;
        isa_pkg::reg_addr_t dst;
    } ex_mem_t;

    typedef struct packed {
        logic               reg_write;
        isa_pkg::word_t     data;
        isa_pkg::reg_addr_t dst;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: hw/hazard_if.sv
//--------------------
// hazard_if
// source-register query from decode, stall answer from the hazard unit
//--------------------
`timescale 1ns/1ns
`default_nettype none

interface hazard_if;

    isa_pkg::reg_addr_t rs;
    isa_pkg::reg_addr_t rt;
    logic               uses_rs;
    logic               uses_rt;
    logic               stall;

    modport query (output rs, rt, uses_rs, uses_rt, input stall);
    modport check (input rs, rt, uses_rs, uses_rt, output stall);

endinterface

`default_nettype wire

// File: hw/pipe_reg.sv
//--------------------
// pipe_reg
// stage register for any payload, loads a bubble when not loading
//--------------------
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
    parameter type T      = logic [31:0],
    parameter T    BUBBLE = T'('0)
) (
    input  wire logic SYS_clk,
    input  wire logic SYS_reset,
    input  wire logic load,
    input  wire T     d,
    output T          q
);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || !load)
            q <= BUBBLE;    // empty slot flows on
        else
            q <= d;
    end

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
//--------------------
// fetch_unit
// PC and the one-entry fetch-to-decode register
//--------------------
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
    parameter isa_pkg::word_t RESET_PC = '0
) (
    input  wire logic           SYS_clk,
    input  wire logic           SYS_reset,
    output isa_pkg::word_t      imem_addr,
    input  wire isa_pkg::word_t imem_data,
    output logic                d_valid,
    output isa_pkg::word_t      d_instr,
    input  wire logic           d_ready
);

    isa_pkg::word_t pc;
    logic           load;

    assign load      = !d_valid || d_ready;    // slot empty or handed over
    assign imem_addr = pc;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            pc      <= RESET_PC;
            d_valid <= 1'b0;
        end
        else if (load)
        begin
            pc      <= pc + 32'd4;
            d_valid <= 1'b1;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (load)
            d_instr <= imem_data;
    end

    // decode holds off, so the offered word must not move
    a_hold_instr: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (d_valid && !d_ready) |=> (d_valid && $stable(d_instr) && $stable(pc)));

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
//--------------------
// decode_stage
// register file, control decode, immediate and destination select
//--------------------
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  wire logic             SYS_clk,
    input  wire logic             SYS_reset,
    input  wire logic             d_valid,
    input  wire isa_pkg::word_t   d_instr,
    output logic                  d_ready,
    hazard_if.query               hz,
    input  wire core_pkg::mem_wb_t wb,
    output core_pkg::id_ex_t      id_out
);

    isa_pkg::word_t    rf [0:isa_pkg::NUM_REGS-1];
    isa_pkg::r_type_t  instr_r;
    isa_pkg::i_type_t  instr_i;
    core_pkg::ctrl_t   ctrl;
    core_pkg::alu_op_e alu_fn;
    logic              fn_ok;
    logic              supported;

    assign instr_r = isa_pkg::r_type_t'(d_instr);
    assign instr_i = isa_pkg::i_type_t'(d_instr);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            rf[0] <= '0;                        // r0 reads as zero
        else if (wb.reg_write && wb.dst != '0)   // r0 stays zero
            rf[wb.dst] <= wb.data;
    end

    always_comb
    begin
        ctrl      = core_pkg::ctrl_nop;
        alu_fn    = core_pkg::alu_add;
        fn_ok     = 1'b1;
        supported = 1'b1;
        case (instr_r.funct)
            isa_pkg::fn_add: alu_fn = core_pkg::alu_add;
            isa_pkg::fn_sub: alu_fn = core_pkg::alu_sub;
            isa_pkg::fn_and: alu_fn = core_pkg::alu_and;
            isa_pkg::fn_or:  alu_fn = core_pkg::alu_or;
            isa_pkg::fn_slt: alu_fn = core_pkg::alu_slt;
            default:         fn_ok  = 1'b0;
        endcase
        case (instr_r.opcode)
            isa_pkg::op_rtype:
            begin
                supported      = fn_ok;    // unknown funct is a bubble too
                ctrl.reg_write = fn_ok;
                ctrl.uses_rt   = fn_ok;
                ctrl.alu_op    = alu_fn;
            end
            isa_pkg::op_addi:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            isa_pkg::op_lw:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            isa_pkg::op_sw:
            begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;    // address = rs + imm
                ctrl.uses_rt   = 1'b1;    // store data
            end
            default: supported = 1'b0;
        endcase
    end

    assign hz.rs      = instr_r.rs;
    assign hz.rt      = instr_r.rt;
    assign hz.uses_rs = d_valid && supported;
    assign hz.uses_rt = d_valid && ctrl.uses_rt;
    assign d_ready    = !hz.stall;

    assign id_out.ctrl   = ctrl;
    assign id_out.rs_val = rf[instr_r.rs];
    assign id_out.rt_val = rf[instr_r.rt];
    assign id_out.imm    = {{16{instr_i.imm[15]}}, instr_i.imm};
    assign id_out.dst    = (instr_r.opcode == isa_pkg::op_rtype) ? instr_r.rd : instr_i.rt;

    // a writeback aimed at r0 must leave it reading zero
    a_r0_kept: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (wb.reg_write && wb.dst == '0) |=> (rf[0] == '0));

endmodule

`default_nettype wire

// File: hw/hazard_unit.sv
//--------------------
// hazard_unit
// stalls decode while an in-flight instruction writes one of its sources
//--------------------
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    hazard_if.check                hz,
    input  wire isa_pkg::reg_addr_t ex_dst,
    input  wire isa_pkg::reg_addr_t mem_dst,
    input  wire isa_pkg::reg_addr_t wb_dst,
    input  wire logic               ex_wr,
    input  wire logic               mem_wr,
    input  wire logic               wb_wr
);

    logic rs_hit;
    logic rt_hit;

    function automatic logic pending(input isa_pkg::reg_addr_t src,
                                     input isa_pkg::reg_addr_t e_dst, input logic e_wr,
                                     input isa_pkg::reg_addr_t m_dst, input logic m_wr,
                                     input isa_pkg::reg_addr_t w_dst, input logic w_wr);
        logic hit;
        hit = (e_wr && e_dst == src) ||
              (m_wr && m_dst == src) ||
              (w_wr && w_dst == src);    // wb counts, rf write lands at end of cycle
        return hit && (src != '0);        // r0 never waits
    endfunction

    assign rs_hit   = hz.uses_rs && pending(hz.rs, ex_dst, ex_wr, mem_dst, mem_wr, wb_dst, wb_wr);
    assign rt_hit   = hz.uses_rt && pending(hz.rt, ex_dst, ex_wr, mem_dst, mem_wr, wb_dst, wb_wr);
    assign hz.stall = rs_hit || rt_hit;

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
//--------------------
// execute_stage
// operand select and ALU
//--------------------
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  wire core_pkg::id_ex_t id_in,
    output core_pkg::ex_mem_t     ex_out
);

    isa_pkg::word_t op_a;
    isa_pkg::word_t op_b;
    isa_pkg::word_t result;

    assign op_a = id_in.rs_val;
    assign op_b = id_in.ctrl.use_imm ? id_in.imm : id_in.rt_val;

    always_comb
    begin
        case (id_in.ctrl.alu_op)
            core_pkg::alu_add: result = op_a + op_b;
            core_pkg::alu_sub: result = op_a - op_b;
            core_pkg::alu_and: result = op_a & op_b;
            core_pkg::alu_or:  result = op_a | op_b;
            core_pkg::alu_slt: result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            default:           result = '0;
        endcase
    end

    assign ex_out.ctrl       = id_in.ctrl;
    assign ex_out.alu_result = result;          // also the dmem address
    assign ex_out.store_data = id_in.rt_val;
    assign ex_out.dst        = id_in.dst;

endmodule

`default_nettype wire

// File: hw/cpu_core.sv
//--------------------
// cpu_core
// five-stage in-order core with external instruction and data memory
//--------------------
`timescale 1ns/1ns
`default_nettype none

module cpu_core #(
    parameter isa_pkg::word_t RESET_PC = '0
) (
    input  wire logic           SYS_clk,
    input  wire logic           SYS_reset,
    output isa_pkg::word_t      imem_addr,
    input  wire isa_pkg::word_t imem_data,
    output isa_pkg::word_t      dmem_addr,
    output isa_pkg::word_t      dmem_wdata,
    output logic                dmem_we,
    output logic                dmem_re,
    input  wire isa_pkg::word_t dmem_rdata
);

    localparam core_pkg::id_ex_t  id_ex_bubble  = '{ctrl: core_pkg::ctrl_nop, default: '0};
    localparam core_pkg::ex_mem_t ex_mem_bubble = '{ctrl: core_pkg::ctrl_nop, default: '0};
    localparam core_pkg::mem_wb_t mem_wb_bubble =
        '{reg_write: core_pkg::ctrl_nop.reg_write, default: '0};

    logic              d_valid;
    logic              d_ready;
    isa_pkg::word_t    d_instr;
    logic              issue;
    core_pkg::id_ex_t  id_d;
    core_pkg::id_ex_t  id_ex_q;
    core_pkg::ex_mem_t ex_d;
    core_pkg::ex_mem_t ex_mem_q;
    core_pkg::mem_wb_t mem_d;
    core_pkg::mem_wb_t mem_wb_q;

    hazard_if hz ();

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .d_valid   (d_valid),
        .d_instr   (d_instr),
        .d_ready   (d_ready)
    );

    decode_stage u_decode (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .d_valid   (d_valid),
        .d_instr   (d_instr),
        .d_ready   (d_ready),
        .hz        (hz.query),
        .wb        (mem_wb_q),
        .id_out    (id_d)
    );

    hazard_unit u_hazard (
        .hz      (hz.check),
        .ex_dst  (id_ex_q.dst),
        .mem_dst (ex_mem_q.dst),
        .wb_dst  (mem_wb_q.dst),
        .ex_wr   (id_ex_q.ctrl.reg_write),
        .mem_wr  (ex_mem_q.ctrl.reg_write),
        .wb_wr   (mem_wb_q.reg_write)
    );

    assign issue = d_valid && !hz.stall;    // otherwise a bubble goes to EX

    pipe_reg #(.T(core_pkg::id_ex_t), .BUBBLE(id_ex_bubble)) u_id_ex (
        .SYS_clk (SYS_clk), .SYS_reset (SYS_reset), .load (issue), .d (id_d), .q (id_ex_q)
    );

    execute_stage u_execute (
        .id_in  (id_ex_q),
        .ex_out (ex_d)
    );

    pipe_reg #(.T(core_pkg::ex_mem_t), .BUBBLE(ex_mem_bubble)) u_ex_mem (
        .SYS_clk (SYS_clk), .SYS_reset (SYS_reset), .load (1'b1), .d (ex_d), .q (ex_mem_q)
    );

    assign dmem_addr  = ex_mem_q.alu_result;
    assign dmem_wdata = ex_mem_q.store_data;
    assign dmem_we    = ex_mem_q.ctrl.mem_write;
    assign dmem_re    = ex_mem_q.ctrl.mem_read;

    assign mem_d.reg_write = ex_mem_q.ctrl.reg_write;
    assign mem_d.data      = ex_mem_q.ctrl.mem_read ? dmem_rdata : ex_mem_q.alu_result;
    assign mem_d.dst       = ex_mem_q.dst;

    pipe_reg #(.T(core_pkg::mem_wb_t), .BUBBLE(mem_wb_bubble)) u_mem_wb (
        .SYS_clk (SYS_clk), .SYS_reset (SYS_reset), .load (1'b1), .d (mem_d), .q (mem_wb_q)
    );

    // decode never sets both, and bubbles carry neither
    a_dmem_excl: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(dmem_we && dmem_re));

endmodule

`default_nettype wire

// File: bench/tb_cpu_core.sv
//--------------------
// tb_cpu_core
// memory models, reference model and directed tests for the core
//--------------------
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_core;

    localparam isa_pkg::word_t RESET_PC  = 32'h0000_0040;
    localparam int             ROM_WORDS = 64;
    localparam int             RAM_WORDS = 256;

    logic           SYS_clk = 1'b0;
    logic           SYS_reset;
    isa_pkg::word_t imem_addr;
    isa_pkg::word_t imem_data;
    isa_pkg::word_t dmem_addr;
    isa_pkg::word_t dmem_wdata;
    logic           dmem_we;
    logic           dmem_re;
    isa_pkg::word_t dmem_rdata;

    isa_pkg::word_t rom [0:ROM_WORDS-1];
    isa_pkg::word_t ram [0:RAM_WORDS-1];
    isa_pkg::word_t ref_ram [0:RAM_WORDS-1];
    isa_pkg::word_t prog [0:ROM_WORDS-1];
    isa_pkg::word_t obs_addr [$];
    isa_pkg::word_t obs_data [$];
    isa_pkg::word_t exp_addr [$];
    isa_pkg::word_t exp_data [$];
    isa_pkg::word_t rom_idx;
    int             prog_len;
    int             value_errors;
    int             other_errors;
    logic [31:0]    rng;

    cpu_core #(.RESET_PC(RESET_PC)) DUT (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    always #10 SYS_clk = ~SYS_clk;

    assign rom_idx    = (imem_addr - RESET_PC) >> 2;
    assign imem_data  = (rom_idx < ROM_WORDS) ? rom[rom_idx[5:0]] : '0;    // zero runs as bubble
    assign dmem_rdata = dmem_re ? ram[dmem_addr[9:2]] : '0;

    function automatic isa_pkg::word_t fill_word(input int idx);
        return 32'h5a5a_0000 ^ isa_pkg::word_t'(idx * 4);    // tagged by byte address
    endfunction

    // data memory, writes on the rising edge and logs every store
    always @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < RAM_WORDS; i++)
                ram[i] <= fill_word(i);
            obs_addr.delete();
            obs_data.delete();
        end
        else if (dmem_we)
        begin
            ram[dmem_addr[9:2]] <= dmem_wdata;
            obs_addr.push_back(dmem_addr);
            obs_data.push_back(dmem_wdata);
        end
    end

    function automatic isa_pkg::word_t r_instr(input logic [5:0] fn,
                                               input isa_pkg::reg_addr_t rd,
                                               input isa_pkg::reg_addr_t rs,
                                               input isa_pkg::reg_addr_t rt);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic isa_pkg::word_t i_instr(input logic [5:0] op,
                                               input isa_pkg::reg_addr_t rt,
                                               input isa_pkg::reg_addr_t rs,
                                               input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [5:0] pick_funct(input logic [2:0] v);
        case (v)
            3'd0, 3'd5: return isa_pkg::fn_add;
            3'd1, 3'd6: return isa_pkg::fn_sub;
            3'd2, 3'd7: return isa_pkg::fn_and;
            3'd3:       return isa_pkg::fn_or;
            default:    return isa_pkg::fn_slt;
        endcase
    endfunction

    task automatic emit(input isa_pkg::word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic check_word(input string name, input isa_pkg::word_t exp,
                              input isa_pkg::word_t act);
        if (act !== exp)
        begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_addr(input string name, input isa_pkg::word_t exp,
                              input isa_pkg::word_t act);
        if (act !== exp)
        begin
            $display("ERROR at %0t ns: %s expected address 0x%h, got 0x%h",
                     $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    // architectural model, one instruction at a time in program order
    task automatic run_reference();
        isa_pkg::word_t regs [0:31];
        isa_pkg::word_t ins;
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t imm;
        isa_pkg::word_t res;
        logic           ok;
        for (int r = 0; r < 32; r++)
            regs[r] = '0;
        for (int i = 0; i < RAM_WORDS; i++)
            ref_ram[i] = fill_word(i);
        exp_addr.delete();
        exp_data.delete();
        for (int pc = 0; pc < prog_len; pc++)
        begin
            ins = prog[pc];
            a   = regs[ins[25:21]];
            b   = regs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            res = a + imm;    // addi result, lw/sw address
            ok  = 1'b1;
            case (ins[31:26])
                isa_pkg::op_rtype:
                begin
                    case (ins[5:0])
                        isa_pkg::fn_add: res = a + b;
                        isa_pkg::fn_sub: res = a - b;
                        isa_pkg::fn_and: res = a & b;
                        isa_pkg::fn_or:  res = a | b;
                        isa_pkg::fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:         ok  = 1'b0;
                    endcase
                    if (ok)
                        regs[ins[15:11]] = res;
                end
                isa_pkg::op_addi: regs[ins[20:16]] = res;
                isa_pkg::op_lw:   regs[ins[20:16]] = ref_ram[res[9:2]];
                isa_pkg::op_sw:
                begin
                    ref_ram[res[9:2]] = b;
                    exp_addr.push_back(res);
                    exp_data.push_back(b);
                end
                default: ok = 1'b0;
            endcase
            regs[0] = '0;    // r0 hardwired
        end
    endtask

    // reset for 10 cycles, loads the ROM and checks the idle outputs
    task automatic restart_core();
        @(posedge SYS_clk);
        SYS_reset <= 1'b1;
        @(posedge SYS_clk);
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i] = (i < prog_len) ? prog[i] : '0;
        for (int c = 0; c < 9; c++)
        begin
            @(negedge SYS_clk);
            check_bit("dmem_we", 1'b0, dmem_we);
            check_bit("dmem_re", 1'b0, dmem_re);
            check_addr("imem_addr", RESET_PC, imem_addr);
            @(posedge SYS_clk);
        end
        SYS_reset <= 1'b0;
        @(negedge SYS_clk);
        check_addr("imem_addr", RESET_PC, imem_addr);    // no transfer yet
        check_bit("dmem_we", 1'b0, dmem_we);
    endtask

    task automatic wait_stores(input int n);
        int cyc;
        cyc = 0;
        while (obs_addr.size() < n && cyc < 500)
        begin
            @(negedge SYS_clk);
            cyc++;
        end
        if (obs_addr.size() < n)
        begin
            $display("timeout at %0t ns: only %0d of %0d stores ever arrived",
                     $time, obs_addr.size(), n);
            other_errors++;
        end
    endtask

    task automatic run_program(input string name);
        run_reference();
        restart_core();
        wait_stores(exp_addr.size());
        if (obs_addr.size() != exp_addr.size())
        begin
            $display("%s: saw %0d stores where %0d were expected",
                     name, obs_addr.size(), exp_addr.size());
            other_errors++;
        end
        for (int i = 0; i < exp_addr.size() && i < obs_addr.size(); i++)
        begin
            check_addr("dmem_addr", exp_addr[i], obs_addr[i]);
            check_word("dmem_wdata", exp_data[i], obs_data[i]);
        end
    endtask

    task automatic reset_state();
        prog_len = 0;
        restart_core();
    endtask

    task automatic addi_stores();
        prog_len = 0;
        emit(i_instr(isa_pkg::op_addi, 5'd1, 5'd0, 16'h0123));
        emit(i_instr(isa_pkg::op_addi, 5'd2, 5'd0, 16'hfffb));     // -5
        emit(i_instr(isa_pkg::op_addi, 5'd3, 5'd0, 16'h7fff));
        emit(i_instr(isa_pkg::op_addi, 5'd4, 5'd0, 16'h8000));     // most negative
        emit(i_instr(isa_pkg::op_addi, 5'd10, 5'd0, 16'h0100));
        emit(i_instr(isa_pkg::op_sw, 5'd1, 5'd10, 16'h0000));
        emit(i_instr(isa_pkg::op_sw, 5'd2, 5'd10, 16'h0004));
        emit(i_instr(isa_pkg::op_sw, 5'd3, 5'd10, 16'h0008));
        emit(i_instr(isa_pkg::op_sw, 5'd4, 5'd10, 16'hfffc));      // negative offset
        run_program("addi_stores");
    endtask

    task automatic dependent_rtype();
        prog_len = 0;
        emit(i_instr(isa_pkg::op_addi, 5'd1, 5'd0, 16'h0007));
        emit(i_instr(isa_pkg::op_addi, 5'd2, 5'd0, 16'hfffd));
        emit(r_instr(isa_pkg::fn_add, 5'd3, 5'd1, 5'd2));
        emit(r_instr(isa_pkg::fn_sub, 5'd4, 5'd3, 5'd1));
        emit(r_instr(isa_pkg::fn_and, 5'd5, 5'd4, 5'd1));
        emit(r_instr(isa_pkg::fn_or, 5'd6, 5'd5, 5'd2));
        emit(r_instr(isa_pkg::fn_slt, 5'd7, 5'd2, 5'd1));
        emit(r_instr(isa_pkg::fn_slt, 5'd8, 5'd1, 5'd2));         // 0 only if signed
        for (int r = 3; r < 9; r++)
            emit(i_instr(isa_pkg::op_sw, isa_pkg::reg_addr_t'(r), 5'd0, 16'(32'h200 + r * 4)));
        run_program("dependent_rtype");
    endtask

    task automatic load_use();
        prog_len = 0;
        emit(i_instr(isa_pkg::op_addi, 5'd9, 5'd0, 16'h0300));
        emit(i_instr(isa_pkg::op_addi, 5'd5, 5'd0, 16'hffb3));
        emit(i_instr(isa_pkg::op_sw, 5'd5, 5'd9, 16'h0010));
        emit(i_instr(isa_pkg::op_lw, 5'd1, 5'd9, 16'h0010));
        emit(i_instr(isa_pkg::op_addi, 5'd2, 5'd1, 16'h0011));     // uses the load at once
        emit(i_instr(isa_pkg::op_sw, 5'd2, 5'd9, 16'h0000));
        emit(i_instr(isa_pkg::op_lw, 5'd3, 5'd9, 16'h0020));       // untouched fill word
        emit(r_instr(isa_pkg::fn_add, 5'd4, 5'd3, 5'd1));
        emit(i_instr(isa_pkg::op_sw, 5'd4, 5'd9, 16'h0004));
        run_program("load_use");
    endtask

    task automatic zero_register();
        prog_len = 0;
        emit(i_instr(isa_pkg::op_addi, 5'd0, 5'd0, 16'h0055));
        emit(i_instr(isa_pkg::op_sw, 5'd0, 5'd0, 16'h0080));
        emit(i_instr(isa_pkg::op_addi, 5'd1, 5'd0, 16'h0001));
        emit(i_instr(isa_pkg::op_sw, 5'd1, 5'd0, 16'h0084));
        run_program("zero_register");
        if (obs_data.size() > 0)
            check_word("dmem_wdata", 32'd0, obs_data[0]);
    endtask

    task automatic random_mix();
        isa_pkg::reg_addr_t rd;
        isa_pkg::reg_addr_t rs;
        isa_pkg::reg_addr_t rt;
        prog_len = 0;
        for (int r = 1; r < 8; r++)
        begin
            rng = xorshift(rng);
            emit(i_instr(isa_pkg::op_addi, isa_pkg::reg_addr_t'(r), 5'd0, rng[15:0]));
        end
        for (int k = 0; k < 20; k++)
        begin
            rng = xorshift(rng);
            rd  = isa_pkg::reg_addr_t'(rng[20:18] % 7 + 1);
            rs  = isa_pkg::reg_addr_t'(rng[23:21] % 7 + 1);
            rt  = isa_pkg::reg_addr_t'(rng[26:24] % 7 + 1);
            if (rng[27])
                emit(i_instr(isa_pkg::op_addi, rd, rs, rng[15:0]));
            else
                emit(r_instr(pick_funct(rng[30:28]), rd, rs, rt));
            if (k % 2 == 1)
                emit(i_instr(isa_pkg::op_sw, rd, 5'd0, 16'(32'h200 + k * 4)));
        end
        run_program("random_mix");
    endtask

    initial
    begin
        SYS_reset    = 1'b1;
        rng          = 32'd33;
        prog_len     = 0;
        value_errors = 0;
        other_errors = 0;
        reset_state();
        addi_stores();
        dependent_rtype();
        load_use();
        zero_register();
        random_mix();
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hw/isa_pkg.sv
hw/core_pkg.sv
hw/hazard_if.sv
hw/pipe_reg.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/cpu_core.sv
bench/tb_cpu_core.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f \
    --top-module tb_cpu_core -Mdir obj_dir -o tb_cpu_core_sim

./obj_dir/tb_cpu_core_sim > sim.log 2>&1 || true
cat sim.log

grep -q "^TESTS PASSED$" sim.log
